/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    // Bits 11..8 pick the slave page, bits 7..0 the register
    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [APB_DW-1:0] apb_data_t;

    typedef enum logic [1:0] {
        SEL_GPIO = 2'd0,
        SEL_SPI  = 2'd1,
        SEL_NONE = 2'd2
    } slave_sel_e;

    typedef enum logic [7:0] {
        REG_SWITCH = 8'h00,
        REG_LED    = 8'h04,
        REG_SEG    = 8'h08,
        REG_DP     = 8'h0C
    } gpio_reg_e;

    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00,
        REG_DATA   = 8'h04,
        REG_STATUS = 8'h08
    } spi_reg_e;

    typedef enum logic {
        SPI_IDLE  = 1'b0,
        SPI_SHIFT = 1'b1
    } spi_state_e;

endpackage

`default_nettype wire

/* hw/apb_if.sv */
`default_nettype none

interface apb_if import soc_pkg::*; ();

    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    modport master (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

/* hw/apb_decoder.sv */
`default_nettype none

module apb_decoder import soc_pkg::*; (
    input  wire    clk,
    input  wire    rst_n_i,
    apb_if.slave   host,
    apb_if.master  gpio,
    apb_if.master  spi
);

    slave_sel_e sel;

    always_comb begin
        case (host.paddr[11:8])
            4'h0:    sel = SEL_GPIO;
            4'h1:    sel = SEL_SPI;
            default: sel = SEL_NONE;
        endcase
    end

    // Shared request lines, only psel is steered
    assign gpio.paddr   = host.paddr;
    assign gpio.penable = host.penable;
    assign gpio.pwrite  = host.pwrite;
    assign gpio.pwdata  = host.pwdata;
    assign gpio.psel    = host.psel && (sel == SEL_GPIO);

    assign spi.paddr    = host.paddr;
    assign spi.penable  = host.penable;
    assign spi.pwrite   = host.pwrite;
    assign spi.pwdata   = host.pwdata;
    assign spi.psel     = host.psel && (sel == SEL_SPI);

    always_comb begin
        case (sel)
            SEL_GPIO: begin
                host.prdata  = gpio.prdata;
                host.pready  = gpio.pready;
                host.pslverr = gpio.pslverr;
            end
            SEL_SPI: begin
                host.prdata  = spi.prdata;
                host.pready  = spi.pready;
                host.pslverr = spi.pslverr;
            end
            default: begin
                // Unmapped page, answered here with an error
                host.prdata  = '0;
                host.pready  = 1'b1;
                host.pslverr = host.psel && host.penable;
            end
        endcase
    end

    a_one_slave: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(gpio.psel && spi.psel));

endmodule

`default_nettype wire

/* hw/gpio_ctrl.sv */
`default_nettype none

module gpio_ctrl import soc_pkg::*; #(
    parameter int unsigned SCAN_DIV = 50000
) (
    input  wire         clk,
    input  wire         rst_n_i,
    apb_if.slave        bus,
    input  wire  [7:0]  switch_i,
    output logic [15:0] led_o,
    output logic [7:0]  seg_sel_o,
    output logic [7:0]  seg_bit_o
);

    localparam int CNT_W = $clog2(SCAN_DIV + 1);

    logic [7:0]       sw_meta;
    logic [7:0]       sw_sync;
    logic [31:0]      seg_q;
    logic [7:0]       dp_q;
    logic [CNT_W-1:0] scan_cnt;
    logic [2:0]       digit;
    logic [3:0]       nibble;
    logic             wr_en;

    assign wr_en = bus.psel && bus.penable && bus.pwrite;

    // Two-flop synchronizer for the switches
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= switch_i;
            sw_sync <= sw_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            led_o <= '0;
            seg_q <= '0;
            dp_q  <= '0;
        end else if (wr_en) begin
            case (bus.paddr[7:0])
                REG_LED: led_o <= bus.pwdata[15:0];
                REG_SEG: seg_q <= bus.pwdata;
                REG_DP:  dp_q  <= bus.pwdata[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (bus.paddr[7:0])
            REG_SWITCH: bus.prdata = {24'h0, sw_sync};
            REG_LED:    bus.prdata = {16'h0, led_o};
            REG_SEG:    bus.prdata = seg_q;
            REG_DP:     bus.prdata = {24'h0, dp_q};
            default:    bus.prdata = '0;
        endcase
    end

    assign bus.pready  = 1'b1;
    assign bus.pslverr = 1'b0;

    // Digit scan
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scan_cnt <= '0;
            digit    <= '0;
        end else if (scan_cnt == CNT_W'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 3'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    function automatic logic [6:0] hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0: hex_to_seg = 7'h3F;
            4'h1: hex_to_seg = 7'h06;
            4'h2: hex_to_seg = 7'h5B;
            4'h3: hex_to_seg = 7'h4F;
            4'h4: hex_to_seg = 7'h66;
            4'h5: hex_to_seg = 7'h6D;
            4'h6: hex_to_seg = 7'h7D;
            4'h7: hex_to_seg = 7'h07;
            4'h8: hex_to_seg = 7'h7F;
            4'h9: hex_to_seg = 7'h6F;
            4'hA: hex_to_seg = 7'h77;
            4'hB: hex_to_seg = 7'h7C;
            4'hC: hex_to_seg = 7'h39;
            4'hD: hex_to_seg = 7'h5E;
            4'hE: hex_to_seg = 7'h79;
            default: hex_to_seg = 7'h71;
        endcase
    endfunction

    assign nibble    = seg_q[digit*4 +: 4];
    assign seg_sel_o = ~(8'b1 << digit);
    assign seg_bit_o = {dp_q[digit], hex_to_seg(nibble)};

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot(~seg_sel_o));

endmodule

`default_nettype wire

/* hw/spi_master.sv */
`default_nettype none

module spi_master import soc_pkg::*; #(
    parameter int unsigned CLK_DIV = 8
) (
    input  wire   clk,
    input  wire   rst_n_i,
    apb_if.slave  bus,
    output logic  spi_sck_o,
    output logic  spi_ss_o,
    output logic  spi_mosi_o,
    input  wire   spi_miso_i
);

    localparam int DIV_W = $clog2(2 * CLK_DIV);

    spi_state_e       state;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [7:0]       shift_q;
    logic             miso_q;
    logic             ss_en;
    logic             access;
    logic             data_wr;
    logic             start;
    logic             sck_rise;
    logic             sck_fall;

    assign access   = bus.psel && bus.penable;
    assign data_wr  = access && bus.pwrite && (bus.paddr[7:0] == REG_DATA);
    assign start    = data_wr && (state == SPI_IDLE);
    assign sck_rise = (state == SPI_SHIFT) && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign sck_fall = (state == SPI_SHIFT) && (div_cnt == DIV_W'(2 * CLK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ss_en <= 1'b0;
        end else if (access && bus.pwrite && (bus.paddr[7:0] == REG_CTRL)) begin
            ss_en <= bus.pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= SPI_IDLE;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            shift_q   <= '0;
            spi_sck_o <= 1'b0;
        end else if (start) begin
            state   <= SPI_SHIFT;
            div_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= bus.pwdata[7:0];
        end else if (state == SPI_SHIFT) begin
            div_cnt <= sck_fall ? '0 : div_cnt + 1'b1;
            if (sck_rise) begin
                spi_sck_o <= 1'b1;
            end
            if (sck_fall) begin
                // Received bit enters as the sent one leaves
                spi_sck_o <= 1'b0;
                shift_q   <= {shift_q[6:0], miso_q};
                bit_cnt   <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd7) begin
                    state <= SPI_IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            miso_q <= spi_miso_i;
        end
    end

    assign spi_ss_o   = ~ss_en;
    assign spi_mosi_o = (state == SPI_SHIFT) && shift_q[7];

    always_comb begin
        case (bus.paddr[7:0])
            REG_CTRL:   bus.prdata = {31'h0, ss_en};
            REG_DATA:   bus.prdata = {24'h0, shift_q};
            REG_STATUS: bus.prdata = {31'h0, state == SPI_SHIFT};
            default:    bus.prdata = '0;
        endcase
    end

    assign bus.pready  = 1'b1;
    // Refuse a new byte while one is in flight
    assign bus.pslverr = data_wr && (state == SPI_SHIFT);

    a_sck_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state == SPI_IDLE) |-> !spi_sck_o);

    a_bit_cnt: assert property (@(posedge clk) disable iff (!rst_n_i)
        bit_cnt <= 4'd8);

endmodule

`default_nettype wire

/* hw/periph_top.sv */
`default_nettype none

module periph_top import soc_pkg::*; #(
    parameter int unsigned SCAN_DIV = 50000,
    parameter int unsigned CLK_DIV  = 8
) (
    input  wire         clk,
    input  wire         rst_n_i,
    // APB slave port
    input  apb_addr_t   paddr_i,
    input  wire         psel_i,
    input  wire         penable_i,
    input  wire         pwrite_i,
    input  apb_data_t   pwdata_i,
    output apb_data_t   prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    // GPIO
    input  wire  [7:0]  switch_i,
    output logic [15:0] led_o,
    output logic [7:0]  seg_sel_o,
    output logic [7:0]  seg_bit_o,
    // SPI
    output logic        spi_sck_o,
    output logic        spi_ss_o,
    output logic        spi_mosi_o,
    input  wire         spi_miso_i
);

    apb_if host_bus ();
    apb_if gpio_bus ();
    apb_if spi_bus ();

    assign host_bus.paddr   = paddr_i;
    assign host_bus.psel    = psel_i;
    assign host_bus.penable = penable_i;
    assign host_bus.pwrite  = pwrite_i;
    assign host_bus.pwdata  = pwdata_i;
    assign prdata_o         = host_bus.prdata;
    assign pready_o         = host_bus.pready;
    assign pslverr_o        = host_bus.pslverr;

    apb_decoder apb_decoder_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .host    (host_bus.slave),
        .gpio    (gpio_bus.master),
        .spi     (spi_bus.master)
    );

    gpio_ctrl #(.SCAN_DIV(SCAN_DIV)) gpio_ctrl_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .bus       (gpio_bus.slave),
        .switch_i  (switch_i),
        .led_o     (led_o),
        .seg_sel_o (seg_sel_o),
        .seg_bit_o (seg_bit_o)
    );

    spi_master #(.CLK_DIV(CLK_DIV)) spi_master_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .bus        (spi_bus.slave),
        .spi_sck_o  (spi_sck_o),
        .spi_ss_o   (spi_ss_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

`default_nettype wire

/* tb/periph_top_tb.sv */
`default_nettype none

module periph_top_tb import soc_pkg::*; ();

    localparam int SCAN_DIV = 4;
    localparam int CLK_DIV  = 2;
    localparam int NUM_ROWS = 14;

    typedef enum {K_WRITE, K_READ, K_POLL, K_SCAN, K_SWITCH} row_kind_e;

    // Segments a..g in bits 0..6, indexed by hex value
    localparam logic [6:0] SEG_PAT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic        clk;
    logic        rst_n_i;
    apb_addr_t   paddr_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    apb_data_t   pwdata_i;
    apb_data_t   prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic [7:0]  switch_i;
    logic [15:0] led_o;
    logic [7:0]  seg_sel_o;
    logic [7:0]  seg_bit_o;
    logic        spi_sck_o;
    logic        spi_ss_o;
    logic        spi_mosi_o;
    logic        spi_miso_i;

    string     row_name  [NUM_ROWS];
    row_kind_e row_kind  [NUM_ROWS];
    apb_addr_t row_addr  [NUM_ROWS];
    apb_data_t row_wdata [NUM_ROWS];
    apb_data_t row_exp   [NUM_ROWS];
    logic      row_err   [NUM_ROWS];

    // Expected register state, updated from accepted writes
    logic [15:0] led_model   = '0;
    apb_data_t   seg_model   = '0;
    logic [7:0]  dp_model    = '0;
    logic        ss_model    = 1'b0;
    logic [7:0]  mon_byte    = '0;
    int          scan_cycles = 0;
    integer      seed        = 32'h17dd;
    int          errors      = 0;

    periph_top #(.SCAN_DIV(SCAN_DIV), .CLK_DIV(CLK_DIV)) periph_top_i (.*);

    // SPI loopback
    assign spi_miso_i = spi_mosi_o;

    always #20 clk = ~clk;

    always @(posedge spi_sck_o) begin
        mon_byte <= {mon_byte[6:0], spi_mosi_o};
    end

    // Clock edges since reset release, for the expected digit
    always @(posedge clk) begin
        if (rst_n_i) begin
            scan_cycles <= scan_cycles + 1;
        end
    end

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected pslverr %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_seg(input string name, input logic [7:0] exp_sel,
                             input logic [7:0] exp_bit, input logic [7:0] act_sel,
                             input logic [7:0] act_bit);
        if (act_sel !== exp_sel || act_bit !== exp_bit) begin
            errors++;
            $display("CHECK FAILED %s: expected %h/%h, actual %h/%h",
                     name, exp_sel, exp_bit, act_sel, act_bit);
        end
    endtask

    task automatic check_spi(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected byte %h, actual %h", name, exp, act);
        end
    endtask

    task automatic set_row(input int i, input string name, input row_kind_e kind,
                           input apb_addr_t addr, input apb_data_t wdata,
                           input apb_data_t exp, input logic err);
        row_name[i]  = name;
        row_kind[i]  = kind;
        row_addr[i]  = addr;
        row_wdata[i] = wdata;
        row_exp[i]   = exp;
        row_err[i]   = err;
    endtask

    task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        #2;
        paddr_i  = addr;
        pwrite_i = wr;
        pwdata_i = wdata;
        psel_i   = 1'b1;
        @(posedge clk);
        #2;
        penable_i = 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        check_pin("pready", 1'b1, pready_o);
        @(posedge clk);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Digit k is due once SCAN_DIV edges per digit have passed since reset
    task automatic scan_display(input string name);
        int k;
        repeat (8 * SCAN_DIV) begin
            @(negedge clk);
            k = (scan_cycles / SCAN_DIV) % 8;
            check_seg(name, ~(8'b1 << k), {dp_model[k], SEG_PAT[seg_model[k*4 +: 4]]},
                      seg_sel_o, seg_bit_o);
        end
    endtask

    task automatic run_row(input int i);
        apb_data_t  rdata;
        logic       err;
        logic [7:0] sw_val;
        case (row_kind[i])
            K_WRITE: begin
                apb_access(row_addr[i], 1'b1, row_wdata[i], rdata, err);
                check_err(row_name[i], row_err[i], err);
                if (!row_err[i]) begin
                    case (row_addr[i])
                        12'h004: led_model = row_wdata[i][15:0];
                        12'h008: seg_model = row_wdata[i];
                        12'h00C: dp_model  = row_wdata[i][7:0];
                        12'h100: ss_model  = row_wdata[i][0];
                        default: ;
                    endcase
                end
                check_data(row_name[i], {16'h0, led_model}, {16'h0, led_o});
                check_pin(row_name[i], !ss_model, spi_ss_o);
            end
            K_READ: begin
                apb_access(row_addr[i], 1'b0, '0, rdata, err);
                check_data(row_name[i], row_exp[i], rdata);
                check_err(row_name[i], row_err[i], err);
            end
            K_POLL: begin
                do begin
                    apb_access(row_addr[i], 1'b0, '0, rdata, err);
                end while (rdata[0] !== 1'b0);
                check_data(row_name[i], row_exp[i], rdata);
                check_spi(row_name[i], row_wdata[i][7:0], mon_byte);
            end
            K_SWITCH: begin
                @(posedge clk);
                #2;
                sw_val   = 8'($random(seed));
                switch_i = sw_val;
                repeat (3) @(posedge clk);
                apb_access(row_addr[i], 1'b0, '0, rdata, err);
                check_data(row_name[i], {24'h0, sw_val}, rdata);
                check_err(row_name[i], row_err[i], err);
            end
            default: scan_display(row_name[i]);
        endcase
    endtask

    // Allows for the longest row plus reset
    initial begin
        repeat (8 + NUM_ROWS * (32 * CLK_DIV + 10)) @(posedge clk);
        $display("ERROR: timeout, the tests did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n_i   = 1'b0;
        paddr_i   = '0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = '0;
        switch_i  = '0;
        set_row(0,  "status_reset",   K_READ,   12'h108, 32'h0,         32'h0,         1'b0);
        set_row(1,  "led_write",      K_WRITE,  12'h004, 32'hDEAD_BEEF, 32'h0,         1'b0);
        set_row(2,  "led_read",       K_READ,   12'h004, 32'h0,         32'h0000_BEEF, 1'b0);
        set_row(3,  "switch_read",    K_SWITCH, 12'h000, 32'h0,         32'h0,         1'b0);
        set_row(4,  "seg_write",      K_WRITE,  12'h008, 32'h7654_3210, 32'h0,         1'b0);
        set_row(5,  "dp_write",       K_WRITE,  12'h00C, 32'h05,        32'h0,         1'b0);
        set_row(6,  "seg_scan",       K_SCAN,   12'h000, 32'h0,         32'h0,         1'b0);
        set_row(7,  "spi_ctrl",       K_WRITE,  12'h100, 32'h1,         32'h0,         1'b0);
        set_row(8,  "spi_data",       K_WRITE,  12'h104, 32'hA5,        32'h0,         1'b0);
        set_row(9,  "spi_busy_write", K_WRITE,  12'h104, 32'h3C,        32'h0,         1'b1);
        set_row(10, "spi_poll",       K_POLL,   12'h108, 32'hA5,        32'h0,         1'b0);
        set_row(11, "spi_data_read",  K_READ,   12'h104, 32'h0,         32'hA5,        1'b0);
        set_row(12, "unmapped_write", K_WRITE,  12'h300, 32'h1234,      32'h0,         1'b1);
        set_row(13, "unmapped_read",  K_READ,   12'h300, 32'h0,         32'h0,         1'b1);
        repeat (8) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        check_data("reset_led", '0, {16'h0, led_o});
        check_pin("reset_ss", 1'b1, spi_ss_o);
        check_pin("reset_sck", 1'b0, spi_sck_o);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Tests done with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* periph_top.f */
hw/soc_pkg.sv
hw/apb_if.sv
hw/apb_decoder.sv
hw/gpio_ctrl.sv
hw/spi_master.sv
hw/periph_top.sv
tb/periph_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f periph_top.f \
    --top-module periph_top_tb -o periph_top_sim &&
./obj_dir/periph_top_sim > sim.log 2>&1 &&
grep -q "Simulation finished: PASS" sim.log &&
echo "run_sim: passed" ||
{ echo "run_sim: failed, see sim.log"; exit 1; }
